/* all.f */
+incdir+tests
source/ifu_err_pkg.sv
source/ifu_asi_src_if.sv
source/ifu_tag_check.sv
source/ifu_err_addr_bank.sv
source/ifu_asi_read.sv
source/ifu_errdp.sv
tests/tb_ifu_errdp.sv

/* tests/ifu_errdp_model.svh */
// cycle model of the error datapath, included inside the testbench module
// needs the package import and n_threads declared before the include
// mirrors staging, thread registers, mask and the ldxa register
`ifndef IFU_ERRDP_MODEL_SVH
`define IFU_ERRDP_MODEL_SVH

// staged tags and valid bits, one cycle behind the inputs
way_word_t             m_tags [ic_num_way];
logic [ic_num_way-1:0] m_valid;

// pc is two stages deep, irf and lsu one
err_addr_t             m_pc_s1;
err_addr_t             m_pc_d1;
logic [7:0]            m_irf_reg;
logic [7:0]            m_irf_synd;
err_addr_t             m_lsu;

err_addr_t             m_eadr [n_threads];
imask_t                m_imask;
asi_word_t             m_ldxa;

task automatic reset_model();
   for (int w = 0; w < ic_num_way; w++)
      m_tags[w] = '0;
   for (int t = 0; t < n_threads; t++)
      m_eadr[t] = '0;
   m_valid    = '0;
   m_pc_s1    = '0;
   m_pc_d1    = '0;
   m_irf_reg  = '0;
   m_irf_synd = '0;
   m_lsu      = '0;
   m_imask    = '0;
   m_ldxa     = '0;
endtask

// parity error is set when a word holds an odd number of ones
function automatic logic odd_ones(input logic [33:0] v);
   return ($countones(v) % 2) == 1;
endfunction

// even parity over tag and stored bit of each staged way
function automatic logic [ic_num_way-1:0] tag_parity_vec();
   logic [ic_num_way-1:0] pe;
   for (int w = 0; w < ic_num_way; w++)
      pe[w] = odd_ones({5'b0, m_tags[w]});
   return pe;
endfunction

// register in the low byte, nibble of zeros, then syndrome
function automatic err_addr_t irf_err_addr(input logic [7:0] r, input logic [7:0] s);
   logic [7:0] fixed;
   err_addr_t  a;
   fixed    = r;
   fixed[4] = r[4] ^ (r[5] & r[3]);
   a        = '0;
   a[11:4]  = fixed;
   a[23:16] = s;
   return a;
endfunction

`endif

/* tests/tb_ifu_errdp.sv */
// random stimulus against a cycle model of the error datapath
// n_threads is fixed at 4, so every asi_thr value names a thread
// inputs change just after the rising edge, outputs are sampled at the falling edge
`timescale 1ns/10ps

module tb_ifu_errdp;
   import ifu_err_pkg::*;

   localparam int n_threads    = 4;
   localparam int reset_cycles = 16;
   localparam int test_cycles  = 2000;
   // reset plus random cycles, with about a quarter spare
   localparam int max_cycles   = 2500;

   logic                       rclk = 1'b0;
   logic                       rst_n;
   way_word_t [ic_num_way-1:0] ic_tags;
   logic [ic_num_way-1:0]      ic_valid;
   logic [1:0]                 asi_way;
   fetch_word_t                fet_data;
   fetch_word_t                top_data;
   logic [ic_num_way-1:0]      tag_pe;
   logic                       fet_pe;
   logic                       nir_pe;
   logic [47:0]                pc_f;
   logic [7:0]                 irf_reg;
   logic [7:0]                 irf_synd;
   err_addr_t                  lsu_err_addr;
   logic [n_threads-1:0]       eadr_wr;
   eadr_src_e                  eadr_src;
   logic [1:0]                 asi_thr;
   logic [1:0]                 err_en;
   logic [22:0]                err_stat;
   logic [31:0]                err_inj;
   fetch_word_t                icdata;
   asi_word_t                  asi_wr_data;
   logic                       ld_imask;
   asi_src_e                   asi_src;
   imask_t                     imask;
   asi_word_t                  ldxa_data;
   int unsigned                cycle_cnt = 0;

   `include "ifu_errdp_model.svh"

   ifu_errdp #(.n_threads(n_threads)) UUT (.*);

   always #5 rclk = ~rclk;

   // --------------------
   // ldxa formatting
   // --------------------
   function automatic asi_word_t format_ldxa(input asi_src_e src, input logic [1:0] way,
                                             input logic [1:0] thr);
      asi_word_t w;
      w = '0;
      case (src)
         asi_tag:
         begin
            w[ic_tag_sz-1:0] = m_tags[way][ic_tag_sz-1:0];
            w[32]            = m_tags[way][ic_tag_sz];
            w[34]            = m_valid[way];
         end
         asi_err_en:   w[1:0]  = err_en;
         asi_err_stat: w[31:9] = err_stat;
         asi_err_inj:  w[31:0] = err_inj;
         asi_err_addr: w[47:4] = m_eadr[thr];
         asi_imask:    w[38:0] = m_imask;
         asi_icdata:
         begin
            // each bit moves down one, bit 0 wraps to 33
            for (int i = 0; i < 34; i++)
               w[(i + 33) % 34] = icdata[i];
         end
         default:      w = '0;
      endcase
      return w;
   endfunction

   // one rising edge of the model, using the inputs seen at that edge
   task automatic advance_model();
      asi_word_t ldxa_nxt;
      err_addr_t cap;
      ldxa_nxt = format_ldxa(asi_src, asi_way, asi_thr);
      case (eadr_src)
         eadr_irf: cap = irf_err_addr(m_irf_reg, m_irf_synd);
         eadr_lsu: cap = m_lsu;
         eadr_pc:  cap = m_pc_d1;
         default:  cap = asi_wr_data[47:4];
      endcase
      for (int t = 0; t < n_threads; t++)
         if (eadr_wr[t])
            m_eadr[t] = cap;
      if (ld_imask)
         m_imask = asi_wr_data[38:0];
      m_ldxa     = ldxa_nxt;
      m_pc_d1    = m_pc_s1;
      m_pc_s1    = pc_f[47:4];
      m_irf_reg  = irf_reg;
      m_irf_synd = irf_synd;
      m_lsu      = lsu_err_addr;
      m_valid    = ic_valid;
      for (int w = 0; w < ic_num_way; w++)
         m_tags[w] = ic_tags[w];
   endtask

   // --------------------
   // compare tasks
   // --------------------
   task automatic stop_on_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic expect_pe_vec(input logic [ic_num_way-1:0] got,
                                input logic [ic_num_way-1:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("tag_pe is %b, expected %b", got, exp));
   endtask

   task automatic compare_pe_bit(input logic got, input logic exp, input string name);
      if (got !== exp)
         stop_on_error($sformatf("%s is %b, expected %b", name, got, exp));
   endtask

   task automatic verify_imask(input imask_t got, input imask_t exp);
      if (got !== exp)
         stop_on_error($sformatf("imask is %h, expected %h", got, exp));
   endtask

   task automatic check_ldxa(input asi_word_t got, input asi_word_t exp);
      if (got !== exp)
         stop_on_error($sformatf("ldxa_data is %h, expected %h", got, exp));
   endtask

   task automatic test_outputs();
      expect_pe_vec(tag_pe, tag_parity_vec());
      compare_pe_bit(fet_pe, odd_ones(fet_data), "fet_pe");
      compare_pe_bit(nir_pe, odd_ones(top_data), "nir_pe");
      verify_imask(imask, m_imask);
      check_ldxa(ldxa_data, m_ldxa);
   endtask

   // --------------------
   // stimulus
   // --------------------
   task automatic zero_inputs();
      ic_tags      = '0;
      ic_valid     = '0;
      asi_way      = '0;
      fet_data     = '0;
      top_data     = '0;
      pc_f         = '0;
      irf_reg      = '0;
      irf_synd     = '0;
      lsu_err_addr = '0;
      eadr_wr      = '0;
      eadr_src     = eadr_irf;
      asi_thr      = '0;
      err_en       = '0;
      err_stat     = '0;
      err_inj      = '0;
      icdata       = '0;
      asi_wr_data  = '0;
      ld_imask     = 1'b0;
      asi_src      = asi_none;
   endtask

   task automatic drive_random_inputs();
      logic [31:0] r;
      r = $urandom;
      for (int w = 0; w < ic_num_way; w++)
         ic_tags[w] <= way_word_t'($urandom);
      ic_valid     <= r[3:0];
      asi_way      <= r[5:4];
      asi_thr      <= r[7:6];
      eadr_wr      <= r[8 +: n_threads];
      eadr_src     <= eadr_src_e'(r[13:12]);
      asi_src      <= asi_src_e'(r[16:14]);
      // mask loads about one cycle in four
      ld_imask     <= (r[18:17] == 2'b00);
      err_en       <= r[20:19];
      irf_reg      <= r[28:21];
      irf_synd     <= 8'($urandom);
      err_stat     <= 23'($urandom);
      err_inj      <= $urandom;
      fet_data     <= fetch_word_t'({$urandom, $urandom});
      top_data     <= fetch_word_t'({$urandom, $urandom});
      icdata       <= fetch_word_t'({$urandom, $urandom});
      pc_f         <= 48'({$urandom, $urandom});
      lsu_err_addr <= err_addr_t'({$urandom, $urandom});
      asi_wr_data  <= {$urandom, $urandom};
   endtask

   // --------------------
   // run control
   // --------------------
   always @(posedge rclk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= max_cycles)
      begin
         $display("timeout, the run did not end within %0d cycles", max_cycles);
         $display("Some tests failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   initial
   begin
      int unsigned seed_draw;
      seed_draw = $urandom(19);
      rst_n     = 1'b0;
      zero_inputs();
      reset_model();
      repeat (reset_cycles) @(posedge rclk);
      rst_n <= 1'b1;

      // everything still holds its reset value here
      @(negedge rclk);
      expect_pe_vec(tag_pe, '0);
      verify_imask(imask, '0);
      check_ldxa(ldxa_data, '0);

      repeat (test_cycles)
      begin
         @(posedge rclk);
         advance_model();
         drive_random_inputs();
         @(negedge rclk);
         test_outputs();
      end

      $display("All tests passed");
      $finish;
   end

endmodule

/* source/ifu_errdp.sv */
// fetch error datapath, tag and fetch parity, error addresses, ASI reads
// n_threads sets how many error address registers exist, 1 to 4
// all inputs are levels sampled on rclk, nothing stalls
`timescale 1ns/10ps

module ifu_errdp
#(
   parameter int n_threads = 4
)
(
   input  logic                                                 rclk,
   input  logic                                                 rst_n,
   // tag and fetch checks
   input  ifu_err_pkg::way_word_t [ifu_err_pkg::ic_num_way-1:0] ic_tags,
   input  logic [ifu_err_pkg::ic_num_way-1:0]                   ic_valid,
   input  logic [1:0]                                           asi_way,
   input  ifu_err_pkg::fetch_word_t                             fet_data,
   input  ifu_err_pkg::fetch_word_t                             top_data,
   output logic [ifu_err_pkg::ic_num_way-1:0]                   tag_pe,
   output logic                                                 fet_pe,
   output logic                                                 nir_pe,
   // error address sources
   input  logic [47:0]                                          pc_f,
   input  logic [7:0]                                           irf_reg,
   input  logic [7:0]                                           irf_synd,
   input  ifu_err_pkg::err_addr_t                               lsu_err_addr,
   input  logic [n_threads-1:0]                                 eadr_wr,
   input  ifu_err_pkg::eadr_src_e                               eadr_src,
   input  logic [1:0]                                           asi_thr,
   // ASI read and write
   input  logic [1:0]                                           err_en,
   input  logic [22:0]                                          err_stat,
   input  logic [31:0]                                          err_inj,
   input  ifu_err_pkg::fetch_word_t                             icdata,
   input  ifu_err_pkg::asi_word_t                               asi_wr_data,
   input  logic                                                 ld_imask,
   input  ifu_err_pkg::asi_src_e                                asi_src,
   output ifu_err_pkg::imask_t                                  imask,
   output ifu_err_pkg::asi_word_t                               ldxa_data
);

   ifu_asi_src_if src_if ();

   // --------------------
   // tag and fetch parity
   // --------------------
   ifu_tag_check u_tag_check
   (
      .rclk     (rclk),
      .rst_n    (rst_n),
      .ic_tags  (ic_tags),
      .ic_valid (ic_valid),
      .asi_way  (asi_way),
      .fet_data (fet_data),
      .top_data (top_data),
      .tag_pe   (tag_pe),
      .fet_pe   (fet_pe),
      .nir_pe   (nir_pe),
      .asi      (src_if.tag_src)
   );

   // --------------------
   // error addresses
   // --------------------
   ifu_err_addr_bank #(.n_threads(n_threads)) u_err_addr_bank
   (
      .rclk         (rclk),
      .rst_n        (rst_n),
      .pc_f         (pc_f),
      .irf_reg      (irf_reg),
      .irf_synd     (irf_synd),
      .lsu_err_addr (lsu_err_addr),
      .asi_wr_data  (asi_wr_data),
      .eadr_wr      (eadr_wr),
      .eadr_src     (eadr_src),
      .asi_thr      (asi_thr),
      .asi          (src_if.eadr_src)
   );

   // mask register and load-alternate result
   ifu_asi_read u_asi_read
   (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .err_en      (err_en),
      .err_stat    (err_stat),
      .err_inj     (err_inj),
      .icdata      (icdata),
      .asi_wr_data (asi_wr_data),
      .ld_imask    (ld_imask),
      .asi_src     (asi_src),
      .asi         (src_if.sink),
      .imask       (imask),
      .ldxa_data   (ldxa_data)
   );

endmodule

/* source/ifu_asi_read.sv */
// ldxa_data shows the source chosen in the previous cycle
// imask loads from the ASI store data and holds until the next load
// cache data comes back rotated right by one, bit 0 lands at bit 33
`timescale 1ns/10ps

module ifu_asi_read
(
   input  logic                       rclk,
   input  logic                       rst_n,
   input  logic [1:0]                 err_en,
   input  logic [22:0]                err_stat,
   input  logic [31:0]                err_inj,
   input  ifu_err_pkg::fetch_word_t   icdata,
   input  ifu_err_pkg::asi_word_t     asi_wr_data,
   input  logic                       ld_imask,
   input  ifu_err_pkg::asi_src_e      asi_src,
   ifu_asi_src_if.sink                asi,
   output ifu_err_pkg::imask_t        imask,
   output ifu_err_pkg::asi_word_t     ldxa_data
);
   import ifu_err_pkg::*;

   asi_word_t tag_word;
   asi_word_t eadr_word;
   asi_word_t icd_word;
   asi_word_t ldxa_nxt;

   // --------------------
   // instruction mask
   // --------------------
   always_ff @(posedge rclk)
   begin
      if (!rst_n)
         imask <= '0;
      else if (ld_imask)
         imask <= asi_wr_data[38:0];
   end

   // --------------------
   // read formatting
   // --------------------

   // valid at 34, parity at 32, tag in the low bits
   assign tag_word = {29'b0, asi.tag_valid, 1'b0, asi.tag_par, 4'b0, asi.tag_word};

   assign eadr_word = {16'b0, asi.err_addr, 4'b0};

   assign icd_word = {30'b0, icdata[0], icdata[33:1]};

   always_comb
   begin
      unique case (asi_src)
         asi_none:     ldxa_nxt = '0;
         asi_tag:      ldxa_nxt = tag_word;
         asi_err_en:   ldxa_nxt = {62'b0, err_en};
         asi_err_stat: ldxa_nxt = {32'b0, err_stat, 9'b0};
         asi_err_inj:  ldxa_nxt = {32'b0, err_inj};
         asi_err_addr: ldxa_nxt = eadr_word;
         asi_imask:    ldxa_nxt = {25'b0, imask};
         asi_icdata:   ldxa_nxt = icd_word;
      endcase
   end

   // --------------------
   // load-alternate register
   // --------------------
   always_ff @(posedge rclk)
   begin
      if (!rst_n)
         ldxa_data <= '0;
      else
         ldxa_data <= ldxa_nxt;
   end

   // every 3 bit code names a source, so only an undriven select is illegal
   a_asi_src_legal : assert property (@(posedge rclk) disable iff (!rst_n)
      !$isunknown(asi_src));

endmodule

/* source/ifu_err_addr_bank.sv */
// one error address register per thread, n_threads from 1 to 4
// pc source is two cycles old, irf and lsu sources are one cycle old
// several threads may capture the same source in one cycle
// asi_thr must name an existing thread
`timescale 1ns/10ps

module ifu_err_addr_bank
#(
   parameter int n_threads = 4
)
(
   input  logic                     rclk,
   input  logic                     rst_n,
   input  logic [47:0]              pc_f,
   input  logic [7:0]               irf_reg,
   input  logic [7:0]               irf_synd,
   input  ifu_err_pkg::err_addr_t   lsu_err_addr,
   input  ifu_err_pkg::asi_word_t   asi_wr_data,
   input  logic [n_threads-1:0]     eadr_wr,
   input  ifu_err_pkg::eadr_src_e   eadr_src,
   input  logic [1:0]               asi_thr,
   ifu_asi_src_if.eadr_src          asi
);
   import ifu_err_pkg::*;

   err_addr_t pc_s1;
   err_addr_t pc_d1;
   logic [7:0] irf_reg_w;
   logic [7:0] irf_synd_w;
   logic [7:0] irf_reg_fix;
   err_addr_t irf_eadr;
   err_addr_t lsu_eadr_w;
   err_addr_t eadr_nxt;
   err_addr_t eadr_q [n_threads];

   // --------------------
   // source staging
   // --------------------

   // low pc nibble is never part of an error address
   always_ff @(posedge rclk)
   begin
      if (!rst_n)
      begin
         pc_s1      <= '0;
         pc_d1      <= '0;
         irf_reg_w  <= '0;
         irf_synd_w <= '0;
         lsu_eadr_w <= '0;
      end
      else
      begin
         pc_s1      <= pc_f[47:4];
         pc_d1      <= pc_s1;
         irf_reg_w  <= irf_reg;
         irf_synd_w <= irf_synd;
         lsu_eadr_w <= lsu_err_addr;
      end
   end

   // register number bit 4 corrected by the window bits around it
   assign irf_reg_fix = {irf_reg_w[7:5],
                         irf_reg_w[4] ^ (irf_reg_w[5] & irf_reg_w[3]),
                         irf_reg_w[3:0]};

   // syndrome above the register number, nibble gap between them
   assign irf_eadr = {24'b0, irf_synd_w, 4'b0, irf_reg_fix};

   // --------------------
   // capture
   // --------------------
   always_comb
   begin
      unique case (eadr_src)
         eadr_irf:    eadr_nxt = irf_eadr;
         eadr_lsu:    eadr_nxt = lsu_eadr_w;
         eadr_pc:     eadr_nxt = pc_d1;
         eadr_asi_wr: eadr_nxt = asi_wr_data[47:4];
      endcase
   end

   // unselected threads keep their address
   always_ff @(posedge rclk)
   begin
      if (!rst_n)
      begin
         for (int t = 0; t < n_threads; t++)
            eadr_q[t] <= '0;
      end
      else
      begin
         for (int t = 0; t < n_threads; t++)
         begin
            if (eadr_wr[t])
               eadr_q[t] <= eadr_nxt;
         end
      end
   end

   // --------------------
   // read side
   // --------------------
   assign asi.err_addr = eadr_q[asi_thr];

   // a thread beyond n_threads has no register behind it
   a_asi_thr_range : assert property (@(posedge rclk) disable iff (!rst_n)
      asi_thr < n_threads);

endmodule

/* source/ifu_tag_check.sv */
// tag parity is checked on the copy staged one cycle after the tag input
// fetch parity is combinational on the current words, no staging
// even parity, a set error bit means an odd number of ones was seen
`timescale 1ns/10ps

module ifu_tag_check
(
   input  logic                                                 rclk,
   input  logic                                                 rst_n,
   input  ifu_err_pkg::way_word_t [ifu_err_pkg::ic_num_way-1:0] ic_tags,
   input  logic [ifu_err_pkg::ic_num_way-1:0]                   ic_valid,
   input  logic [1:0]                                           asi_way,
   input  ifu_err_pkg::fetch_word_t                             fet_data,
   input  ifu_err_pkg::fetch_word_t                             top_data,
   output logic [ifu_err_pkg::ic_num_way-1:0]                   tag_pe,
   output logic                                                 fet_pe,
   output logic                                                 nir_pe,
   ifu_asi_src_if.tag_src                                       asi
);
   import ifu_err_pkg::*;

   way_word_t [ic_num_way-1:0] tags_s1;
   logic [ic_num_way-1:0]      valid_s1;
   way_word_t                  asi_tag_s1;

   // --------------------
   // tag staging
   // --------------------
   always_ff @(posedge rclk)
   begin
      if (!rst_n)
      begin
         tags_s1  <= '0;
         valid_s1 <= '0;
      end
      else
      begin
         tags_s1  <= ic_tags;
         valid_s1 <= ic_valid;
      end
   end

   // per-way parity over tag and stored bit
   always_comb
   begin
      for (int w = 0; w < ic_num_way; w++)
         tag_pe[w] = ^tags_s1[w];
   end

   // --------------------
   // fetch parity
   // --------------------
   assign fet_pe = ^fet_data;
   assign nir_pe = ^top_data;

   // --------------------
   // diagnostic tag read
   // --------------------
   assign asi_tag_s1 = tags_s1[asi_way];

   assign asi.tag_word  = asi_tag_s1[ic_tag_sz-1:0];
   assign asi.tag_par   = asi_tag_s1[ic_tag_sz];
   assign asi.tag_valid = valid_s1[asi_way];

   // way select comes from the ASI decode and must be driven out of reset,
   // an unknown here would reach ldxa_data a cycle later
   a_asi_way_known : assert property (@(posedge rclk) disable iff (!rst_n)
      !$isunknown(asi_way));

endmodule

/* source/ifu_asi_src_if.sv */
// read words that the tag and error address blocks offer to the ASI mux
// all signals are plain levels, valid in the cycle they are produced
`timescale 1ns/10ps

interface ifu_asi_src_if;
   import ifu_err_pkg::*;

   // tag of the way picked for diagnostic reads
   logic                 tag_valid;
   logic                 tag_par;
   logic [ic_tag_sz-1:0] tag_word;

   // error address of the thread picked for reads
   err_addr_t            err_addr;

   modport tag_src
   (
      output tag_valid,
      output tag_par,
      output tag_word
   );

   modport eadr_src
   (
      output err_addr
   );

   modport sink
   (
      input tag_valid,
      input tag_par,
      input tag_word,
      input err_addr
   );

endinterface

/* source/ifu_err_pkg.sv */
// shared widths, way count and select codes for the fetch error datapath
// the cache is assumed four-way with a 28 bit tag and one stored parity bit
// error addresses always cover bits 47:4, the low nibble is never kept
package ifu_err_pkg;

   // --------------------
   // sizes
   // --------------------

   // bits in one cache tag
   localparam int ic_tag_sz = 28;

   // ways in the instruction cache
   localparam int ic_num_way = 4;

   // --------------------
   // data words
   // --------------------

   // one way as staged, tag plus its stored parity bit
   // parity sits in the top bit, above the tag
   typedef logic [ic_tag_sz:0] way_word_t;

   // fetched instruction word including predecode bits
   typedef logic [33:0] fetch_word_t;

   // error address, bits 47 down to 4
   typedef logic [47:4] err_addr_t;

   // instruction mask
   typedef logic [38:0] imask_t;

   // one load-alternate read word
   typedef logic [63:0] asi_word_t;

   // --------------------
   // select codes
   // --------------------

   // source of the registered ASI read word
   // asi_none reads back zero
   typedef enum logic [2:0] {
      asi_none,
      asi_tag,
      asi_err_en,
      asi_err_stat,
      asi_err_inj,
      asi_err_addr,
      asi_imask,
      asi_icdata
   } asi_src_e;

   // what a thread error address register captures
   // eadr_asi_wr takes bits 47:4 of the ASI store data
   typedef enum logic [1:0] {
      eadr_irf,
      eadr_lsu,
      eadr_pc,
      eadr_asi_wr
   } eadr_src_e;

endpackage
